/* convLayerSingle.f */
hdl/convPkg.sv
hdl/receptiveFieldSelector.sv
hdl/convSequencer.sv
hdl/convUnit.sv
hdl/outputFeatureBuffer.sv
hdl/convLayerSingle.sv
dv/convLayerSingle_chk.sv
dv/convLayerSingleTb.sv

/* Makefile */
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f convLayerSingle.f --top-module convLayerSingleTb

sim:
	verilator --binary --timing --assert -Mdir obj_dir -f convLayerSingle.f \
		--top-module convLayerSingleTb
	-./obj_dir/VconvLayerSingleTb 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation FAILED, run ended early"; exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf obj_dir $(LOG)

/* dv/convLayerSingleTb.sv */
`timescale 1ns/10ps

module convLayerSingleTb;
	import convPkg::*;

	localparam int D = CONV_D;
	localparam int H = CONV_H;
	localparam int W = CONV_W;
	localparam int F = CONV_F;
	localparam int OH = H - F + 1; // output rows
	localparam int OW = W - F + 1; // output columns
	localparam int TAPS = D * F * F;
	localparam int RESET_CYCLES = 10;
	localparam int DONE_TIMEOUT = 1000; // far above the expected run of under a hundred cycles
	localparam int HOLD_CYCLES = 16;
	localparam int SEED_BASE = 32'h6a37;
	localparam int NUM_CASES = 6;

	typedef enum {caseZeroFilter, caseOnes, caseIdentity, caseExtreme, caseRandom} caseKindT;

	// one row per run, the offset moves the random seed so the two random runs differ
	caseKindT caseKind [NUM_CASES] =
		'{caseZeroFilter, caseOnes, caseIdentity, caseExtreme, caseRandom, caseRandom};
	int caseOffset [NUM_CASES] = '{0, 0, 1, 0, 2, 3};

	logic clk = 1'b0;
	logic reset;
	logic [0:D*H*W*DATA_WIDTH-1] image; // channel, row, column with pixel 0 at the MSB end
	logic [0:TAPS*DATA_WIDTH-1] filter;
	logic [0:OH*OW*DATA_WIDTH-1] outputConv;
	logic done;
	int seed;

	always #4 clk = ~clk; // 8 ns period

	convLayerSingle #(.D(D), .H(H), .W(W), .F(F)) dut0 (
		.clk(clk),
		.reset(reset),
		.image(image),
		.filter(filter),
		.outputConv(outputConv),
		.done(done)
	);

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkPixel(input int index, input pixelT actual, input pixelT expected);
		if (actual !== expected) begin
			stopRun($sformatf("Fail time=%0t signal=outputConv[%0d] got=%0d expected=%0d",
				$time, index, actual, expected));
		end
	endtask

	task automatic checkDone(input logic actual, input logic expected);
		if (actual !== expected) begin
			stopRun($sformatf("Fail time=%0t signal=done got=%b expected=%b",
				$time, actual, expected));
		end
	endtask

	function automatic pixelT pixelAt(input int d, input int r, input int c);
		return image[((d*H + r)*W + c)*DATA_WIDTH +: DATA_WIDTH];
	endfunction

	function automatic pixelT weightAt(input int d, input int i, input int j);
		return filter[(d*F*F + i*F + j)*DATA_WIDTH +: DATA_WIDTH];
	endfunction

	// sum of pixel times weight over the window, only the low DATA_WIDTH bits survive
	function automatic pixelT expectedOutput(input int r, input int c);
		longint sum;
		sum = 0;
		for (int d = 0; d < D; d++)
			for (int i = 0; i < F; i++)
				for (int j = 0; j < F; j++)
					sum += longint'(pixelAt(d, r + i, c + j)) * longint'(weightAt(d, i, j));
		return pixelT'(sum);
	endfunction

	// inputs change on a rising edge while reset is still held
	task automatic fillInputs(input caseKindT kind);
		pixelT value;
		for (int p = 0; p < D*H*W; p++) begin
			case (kind)
				caseOnes: value = pixelT'(1);
				caseExtreme: value = (p % 7 == 3) ? pixelT'(16'h8000 + p)
					: pixelT'(16'h7fff - p); // mostly near the maximum so window sums wrap
				default: value = pixelT'($random(seed)); // random image under every other filter
			endcase
			image[p*DATA_WIDTH +: DATA_WIDTH] <= value;
		end
		for (int t = 0; t < TAPS; t++) begin
			case (kind)
				caseZeroFilter: value = '0;
				caseIdentity: value = (t == 0) ? pixelT'(1) : pixelT'(0); // channel 0 at (0,0)
				caseRandom: value = pixelT'($random(seed));
				default: value = pixelT'(1);
			endcase
			filter[t*DATA_WIDTH +: DATA_WIDTH] <= value;
		end
	endtask

	task automatic checkCleared();
		checkDone(done, 1'b0);
		for (int p = 0; p < OH*OW; p++)
			checkPixel(p, outputConv[p*DATA_WIDTH +: DATA_WIDTH], '0); // buffer clears at reset
	endtask

	task automatic waitForDone();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > DONE_TIMEOUT) stopRun("done did not rise within the timeout");
		end while (done !== 1'b1);
	endtask

	task automatic checkMap();
		for (int r = 0; r < OH; r++)
			for (int c = 0; c < OW; c++)
				checkPixel(r*OW + c, outputConv[(r*OW + c)*DATA_WIDTH +: DATA_WIDTH],
					expectedOutput(r, c));
	endtask

	initial begin
		reset <= 1'b1;
		image <= '0;
		filter <= '0;
		seed = SEED_BASE;
		for (int k = 0; k < NUM_CASES; k++) begin
			@(posedge clk);
			reset <= 1'b1;
			seed = SEED_BASE + caseOffset[k];
			fillInputs(caseKind[k]);
			repeat (RESET_CYCLES - 1) @(posedge clk);
			@(negedge clk);
			checkCleared(); // a second run must not see the previous map
			@(posedge clk);
			reset <= 1'b0;
			waitForDone();
			checkMap();
			for (int i = 0; i < HOLD_CYCLES; i++) begin
				@(negedge clk);
				checkDone(done, 1'b1); // level stays up until the next reset
			end
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* dv/convLayerSingle_chk.sv */
`timescale 1ns/10ps

module convLayerSingle_chk #(
	parameter int D = convPkg::CONV_D,
	parameter int F = convPkg::CONV_F
) (
	input logic clk,
	input logic reset,
	input logic clearAcc,
	input logic storeHalf,
	input logic done,
	input convPkg::tapT tap
);
	import convPkg::*;

	localparam int TAPS = D * F * F;

	// the two strobes come from different states of the sequencer
	strobesExclusive: assert property (@(posedge clk) disable iff (reset)
		!(clearAcc && storeHalf)) else $error("clearAcc and storeHalf high together");

	doneHeld: assert property (@(posedge clk) disable iff (reset) $past(done) |-> done)
		else $error("done fell without a reset");

	// a store is followed by the next clear, or by done once the buffer has written the last half
	storeFollowed: assert property (@(posedge clk) disable iff (reset)
		$past(storeHalf, 2) |-> $past(clearAcc) || done)
		else $error("store was followed by neither a clear nor done");

	tapInRange: assert property (@(posedge clk) disable iff (reset) tap < tapT'(TAPS))
		else $error("tap ran past the last filter position");

endmodule

bind convSequencer convLayerSingle_chk #(.D(D), .F(F)) chk0 (
	.clk(clk),
	.reset(reset),
	.clearAcc(clearAcc),
	.storeHalf(storeHalf),
	.done(done),
	.tap(tap)
);

/* hdl/convLayerSingle.sv */
`timescale 1ns/10ps

module convLayerSingle #(
	parameter int D = convPkg::CONV_D, // depth of image and filter
	parameter int H = convPkg::CONV_H, // image height
	parameter int W = convPkg::CONV_W, // image width
	parameter int F = convPkg::CONV_F  // filter size
) (
	input logic clk,
	input logic reset,
	input logic [0:D*H*W*convPkg::DATA_WIDTH-1] image, // held stable for a whole run
	input logic [0:D*F*F*convPkg::DATA_WIDTH-1] filter, // held stable for a whole run
	output logic [0:(H-F+1)*(W-F+1)*convPkg::DATA_WIDTH-1] outputConv,
	output logic done // level, stays high until the next reset
);
	import convPkg::*;

	localparam int OW = W - F + 1; // output width
	localparam int UNITS = OW / 2; // units working on one half row
	localparam int TAPS = D * F * F;

	// each half row has to be exactly UNITS wide
	if (OW % 2 != 0) begin : genWidthCheck
		$error("convLayerSingle needs an even output width, W-F+1 = %0d", OW);
	end

	coordT rowNumber;
	coordT column;
	coordT halfIndex;
	tapT tap;
	logic clearAcc;
	logic storeHalf;
	logic [0:UNITS*TAPS*DATA_WIDTH-1] receptiveField; // all windows of the current half row
	logic [0:UNITS*DATA_WIDTH-1] unitResults;

	convSequencer #(.D(D), .H(H), .W(W), .F(F)) sequencer0 (
		.clk(clk),
		.reset(reset),
		.done(done),
		.rowNumber(rowNumber),
		.column(column),
		.tap(tap),
		.clearAcc(clearAcc),
		.storeHalf(storeHalf),
		.halfIndex(halfIndex)
	);

	receptiveFieldSelector #(.D(D), .H(H), .W(W), .F(F)) selector0 (
		.image(image),
		.rowNumber(rowNumber),
		.column(column),
		.receptiveField(receptiveField)
	);

	for (genvar n = 0; n < UNITS; n++) begin : genUnit
		convUnit #(.D(D), .F(F)) unit (
			.clk(clk),
			.reset(reset),
			.clearAcc(clearAcc),
			.tap(tap),
			.window(receptiveField[n*TAPS*DATA_WIDTH +: TAPS*DATA_WIDTH]),
			.filter(filter),
			.result(unitResults[n*DATA_WIDTH +: DATA_WIDTH])
		);
	end

	outputFeatureBuffer #(.H(H), .W(W), .F(F)) buffer0 (
		.clk(clk),
		.reset(reset),
		.storeHalf(storeHalf),
		.halfIndex(halfIndex),
		.unitResults(unitResults),
		.outputConv(outputConv),
		.done(done)
	);

endmodule

/* hdl/outputFeatureBuffer.sv */
`timescale 1ns/10ps

module outputFeatureBuffer #(
	parameter int H = convPkg::CONV_H,
	parameter int W = convPkg::CONV_W,
	parameter int F = convPkg::CONV_F
) (
	input logic clk,
	input logic reset,
	input logic storeHalf,
	input convPkg::coordT halfIndex, // which half row the unit results belong to
	input logic [0:((W-F+1)/2)*convPkg::DATA_WIDTH-1] unitResults,
	output logic [0:(H-F+1)*(W-F+1)*convPkg::DATA_WIDTH-1] outputConv, // row-major map
	output logic done
);
	import convPkg::*;

	localparam int SLOT_BITS = ((W - F + 1) / 2) * DATA_WIDTH; // one half row
	localparam int LAST_HALF = 2*(H - F + 1) - 1;

	logic pendingStore; // a store was requested last cycle
	coordT pendingIndex;

	// the slot for halfIndex starts at pixel halfIndex*(W-F+1)/2, which is the
	// row-major position of that half row
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			outputConv <= '0;
			pendingStore <= 1'b0;
			done <= 1'b0;
		end else begin
			pendingStore <= storeHalf;
			if (pendingStore) begin
				outputConv[pendingIndex*SLOT_BITS +: SLOT_BITS] <= unitResults;
				if (pendingIndex == coordT'(LAST_HALF)) begin
					done <= 1'b1; // visible together with the last half row
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (storeHalf) begin
			pendingIndex <= halfIndex; // the sequencer moves on right after the strobe
		end
	end

endmodule

/* hdl/convUnit.sv */
`timescale 1ns/10ps

module convUnit #(
	parameter int D = convPkg::CONV_D,
	parameter int F = convPkg::CONV_F
) (
	input logic clk,
	input logic reset,
	input logic clearAcc,
	input convPkg::tapT tap, // shared by all units
	input logic [0:D*F*F*convPkg::DATA_WIDTH-1] window, // one receptive field in tap order
	input logic [0:D*F*F*convPkg::DATA_WIDTH-1] filter, // weights in the same order
	output convPkg::pixelT result
);
	import convPkg::*;

	pixelT pairPixel; // pixel picked by the previous tap
	pixelT pairWeight; // weight picked by the previous tap
	accT product;
	pixelT acc;

	// full width product, the running sum keeps only the low DATA_WIDTH bits
	assign product = pairPixel * pairWeight;

	// stage 1 picks the pair for the current tap, stage 2 adds the pair picked one
	// cycle earlier, so the sum trails the tap count by a cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pairPixel <= '0;
			pairWeight <= '0;
			acc <= '0;
		end else if (clearAcc) begin
			// the pair taken during the clear cycle would be counted twice, flush it
			pairPixel <= '0;
			pairWeight <= '0;
			acc <= '0;
		end else begin
			pairPixel <= window[tap*DATA_WIDTH +: DATA_WIDTH];
			pairWeight <= filter[tap*DATA_WIDTH +: DATA_WIDTH];
			acc <= acc + pixelT'(product); // wraps at the data width
		end
	end

	// the buffer copies this one cycle after the store strobe, once the final
	// product has been added
	assign result = acc;

endmodule

/* hdl/convSequencer.sv */
`timescale 1ns/10ps

module convSequencer #(
	parameter int D = convPkg::CONV_D,
	parameter int H = convPkg::CONV_H,
	parameter int W = convPkg::CONV_W,
	parameter int F = convPkg::CONV_F
) (
	input logic clk,
	input logic reset,
	input logic done, // high once the buffer holds the whole map
	output convPkg::coordT rowNumber,
	output convPkg::coordT column,
	output convPkg::tapT tap,
	output logic clearAcc, // zeroes every accumulator, one cycle before the first tap
	output logic storeHalf, // all unit results are ready to be stored
	output convPkg::coordT halfIndex // 2*row + half
);
	import convPkg::*;

	localparam int OH = H - F + 1; // output rows
	localparam int UNITS = (W - F + 1) / 2; // output columns per half row
	localparam int TAPS = D * F * F; // accumulate cycles per group
	localparam int LAST_HALF = 2*OH - 1;

	seqStateT state;

	// a group is one clear cycle, TAPS accumulate cycles and one store cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= seqIdle;
			rowNumber <= '0;
			column <= '0;
			halfIndex <= '0;
			tap <= '0;
			clearAcc <= 1'b0;
			storeHalf <= 1'b0;
		end else begin
			case (state)
				seqIdle: if (!done) begin // a finished map is not recomputed before reset
					clearAcc <= 1'b1;
					tap <= '0;
					state <= seqAccumulate;
				end
				seqAccumulate: begin
					clearAcc <= 1'b0;
					if (!clearAcc) begin // tap 0 is held through the clear cycle
						if (tap == tapT'(TAPS-1)) begin
							tap <= '0;
							storeHalf <= 1'b1; // the last product lands while this is high
							state <= seqStore;
						end else begin
							tap <= tap + 1'b1;
						end
					end
				end
				seqStore: begin
					storeHalf <= 1'b0;
					if (halfIndex == coordT'(LAST_HALF)) begin
						state <= seqDone;
					end else begin
						halfIndex <= halfIndex + 1'b1;
						if (column == '0) begin
							column <= coordT'(UNITS); // second half of the same row
						end else begin
							column <= '0;
							rowNumber <= rowNumber + 1'b1;
						end
						clearAcc <= 1'b1; // next group starts right away
						state <= seqAccumulate;
					end
				end
				seqDone: state <= seqDone; // parked until reset
				default: state <= seqIdle;
			endcase
		end
	end

endmodule

/* hdl/receptiveFieldSelector.sv */
`timescale 1ns/10ps

module receptiveFieldSelector #(
	parameter int D = convPkg::CONV_D, // channels
	parameter int H = convPkg::CONV_H, // image rows
	parameter int W = convPkg::CONV_W, // image columns
	parameter int F = convPkg::CONV_F  // filter size
) (
	input logic [0:D*H*W*convPkg::DATA_WIDTH-1] image, // first pixel sits at the MSB end
	input convPkg::coordT rowNumber, // output row being computed
	input convPkg::coordT column, // first output column of the current half row
	output logic [0:((W-F+1)/2)*D*F*F*convPkg::DATA_WIDTH-1] receptiveField
);
	import convPkg::*;

	localparam int UNITS = (W - F + 1) / 2; // one window per unit, half an output row
	localparam int TAPS = D * F * F; // pixels in one window

	// every window is laid out in the same tap order as the filter bus, so a unit can
	// index the window and the filter with the same tap count
	for (genvar n = 0; n < UNITS; n++) begin : genUnit
		for (genvar d = 0; d < D; d++) begin : genChannel
			for (genvar i = 0; i < F; i++) begin : genFilterRow
				for (genvar j = 0; j < F; j++) begin : genFilterCol
					localparam int TAP = d*F*F + i*F + j; // slot inside the window

					// unit n looks at output column column+n, so its window starts there
					assign receptiveField[(n*TAPS + TAP)*DATA_WIDTH +: DATA_WIDTH] =
						image[((d*H + rowNumber + i)*W + column + n + j)*DATA_WIDTH +: DATA_WIDTH];
				end
			end
		end
	end

	// the sequencer keeps rowNumber below H-F+1 and column at 0 or UNITS, so every
	// index above stays inside the image bus for the given geometry

endmodule

/* hdl/convPkg.sv */
package convPkg;

	// pixel, weight and result width; products are kept at twice this before the sum
	parameter int DATA_WIDTH = 16;

	typedef logic signed [DATA_WIDTH-1:0] pixelT; // image pixels, filter weights and output values
	typedef logic signed [2*DATA_WIDTH-1:0] accT; // full product of a pixel and a weight

	// default geometry of the layer
	parameter int CONV_D = 2; // image and filter depth
	parameter int CONV_H = 5; // image height
	parameter int CONV_W = 5; // image width
	parameter int CONV_F = 2; // filter height and width

	// row and column indices, also used for the half row position
	typedef logic [5:0] coordT;

	// position inside one flattened window, channel first then filter row then filter column
	typedef logic [7:0] tapT;

	// the sequencer walks idle -> accumulate -> store and back until the last half row
	typedef enum logic [1:0] {
		seqIdle,
		seqAccumulate,
		seqStore,
		seqDone
	} seqStateT;

endpackage
